// File: rvv_retire.f
+incdir+src
+incdir+sim
src/rvv_retire_pkg.sv
src/rvv_retire_ctrl.sv
src/rvv_retire_strobe.sv
src/rvv_retire_csr.sv
src/rvv_retire.sv
sim/tb_rvv_retire.sv

// File: Bender.yml
package:
  name: rvv_retire

sources:
  - include_dirs:
      - src
    files:
      - src/rvv_retire_pkg.sv
      - src/rvv_retire_ctrl.sv
      - src/rvv_retire_strobe.sv
      - src/rvv_retire_csr.sv
      - src/rvv_retire.sv
  - target: test
    include_dirs:
      - src
      - sim
    files:
      - sim/tb_rvv_retire.sv

// File: sim/tb_rvv_retire_checks.svh
//////////////////////////////
// testbench compare tasks
// typed checks for lane valids, VRF/XRF
// writes, vcsr and single bits
//////////////////////////////

int error_count = 0;
int check_count = 0;

task automatic check_valid(input string name, input rvv_retire_pkg::lane_valid_t exp,
                           input rvv_retire_pkg::lane_valid_t act);
  check_count++;
  if (act !== exp) begin
    $display("ERROR %0t %s expected %b got %b", $time, name, exp, act);
    error_count++;
  end
endtask

task automatic check_vrf(input string name, input rvv_retire_pkg::rt2vrf_t exp,
                         input rvv_retire_pkg::rt2vrf_t act);
  check_count++;
  if (act !== exp) begin
    $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
    error_count++;
  end
endtask

task automatic check_xrf(input string name, input rvv_retire_pkg::rt2xrf_t exp,
                         input rvv_retire_pkg::rt2xrf_t act);
  check_count++;
  if (act !== exp) begin
    $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
    error_count++;
  end
endtask

task automatic check_vcsr(input string name, input rvv_retire_pkg::vcsr_t exp,
                          input rvv_retire_pkg::vcsr_t act);
  check_count++;
  if (act !== exp) begin
    $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
    error_count++;
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  check_count++;
  if (act !== exp) begin
    $display("ERROR %0t %s expected %b got %b", $time, name, exp, act);
    error_count++;
  end
endtask

// File: sim/tb_rvv_retire.sv
//////////////////////////////
// retire stage testbench
// clock, reset, DUT and directed tests
//////////////////////////////

`timescale 1ns/1ps

`include "rvv_retire_consts.svh"

module tb_rvv_retire;

  logic clk = 1'b0;
  logic rst_n;

  rvv_retire_pkg::lane_valid_t               rob_valid, rob_ready, xrf_ready;
  rvv_retire_pkg::lane_valid_t               xrf_valid, vrf_valid;
  rvv_retire_pkg::rob2rt_t [`NUM_RT_UOP-1:0] rob_data;
  rvv_retire_pkg::rt2xrf_t [`NUM_RT_UOP-1:0] xrf_data;
  rvv_retire_pkg::rt2vrf_t [`NUM_RT_UOP-1:0] vrf_data;
  rvv_retire_pkg::vcsr_t                     vcsr_data;
  logic                                      vcsr_valid, vsat_valid;
  logic [`VCSR_VXSAT_WIDTH-1:0]              vsat_data;
  logic [`NUM_RT_UOP-1:0][`VLENB-1:0]        exp_strobe;

  `include "tb_rvv_retire_checks.svh"

  always #20 clk = ~clk;

  rvv_retire i_rvv_retire (
    .rob2rt_write_valid  (rob_valid),
    .rob2rt_write_data   (rob_data),
    .rob2rt_write_ready  (rob_ready),
    .rt2xrf_write_valid  (xrf_valid),
    .rt2xrf_write_data   (xrf_data),
    .rt2xrf_write_ready  (xrf_ready),
    .rt2vrf_write_valid  (vrf_valid),
    .rt2vrf_write_data   (vrf_data),
    .rt2vcsr_write_valid (vcsr_valid),
    .rt2vcsr_write_data  (vcsr_data),
    .rt2vsat_write_valid (vsat_valid),
    .rt2vsat_write_data  (vsat_data)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  // valid entry with random data, byte types and vcsr
  function automatic rvv_retire_pkg::rob2rt_t make_entry(input rvv_retire_pkg::w_type_e t,
                                                         input int idx);
    rvv_retire_pkg::rob2rt_t e;
    logic [63:0]             r;
    e = '0;
    e.w_valid = 1'b1;
    e.w_type  = t;
    e.w_index = `REGFILE_INDEX_WIDTH'(idx);
    for (int k = 0; k < `VLEN / 32; k++)
      e.w_data[k*32 +: 32] = $urandom;
    for (int b = 0; b < `VLENB; b++)
      e.vd_type[b] = 2'($urandom);
    r = {$urandom, $urandom};
    e.vector_csr = r[$bits(rvv_retire_pkg::vcsr_t)-1:0];
    return e;
  endfunction

  function automatic logic [`VLENB-1:0] base_of(input rvv_retire_pkg::rob2rt_t e);
    logic [`VLENB-1:0] s;
    for (int b = 0; b < `VLENB; b++)
      s[b] = (e.vd_type[b] == `VD_BYTE_ACTIVE);
    if (e.ignore_vta || e.ignore_vma)
      s = '1;  // whole register
    return s;
  endfunction

  task automatic step_to_drive();
    @(posedge clk);
    #2;
  endtask

  task automatic step_to_sample();
    #28;  // 30 ns after the edge
  endtask

  task automatic compare_vrf_lanes();
    rvv_retire_pkg::rt2vrf_t exp;
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      exp = {rob_data[i].w_index, rob_data[i].w_data, exp_strobe[i]};
      check_vrf($sformatf("rt2vrf_write_data[%0d]", i), exp, vrf_data[i]);
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while ((rst_n !== 1'b1) && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was not released within %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic distinct_vrf_writes();
    for (int pass = 0; pass < 2; pass++) begin
      step_to_drive();
      for (int i = 0; i < `NUM_RT_UOP; i++) begin
        rob_data[i] = make_entry(rvv_retire_pkg::DST_VRF, i * 3 + 1);
        rob_data[i].ignore_vta = (pass == 1) && (i == 1);
        rob_data[i].ignore_vma = (pass == 1) && (i == 3);
      end
      rob_valid = '1;
      xrf_ready = '1;
      step_to_sample();
      for (int i = 0; i < `NUM_RT_UOP; i++)
        exp_strobe[i] = base_of(rob_data[i]);
      check_valid("rt2vrf_write_valid", '1, vrf_valid);
      check_valid("rob2rt_write_ready", '1, rob_ready);
      compare_vrf_lanes();
    end
  endtask

  task automatic waw_pruning();
    logic [`VLENB-1:0] younger;
    for (int pass = 0; pass < 2; pass++) begin
      step_to_drive();
      for (int i = 0; i < `NUM_RT_UOP; i++)
        rob_data[i] = make_entry(rvv_retire_pkg::DST_VRF,
                                 (pass == 0) ? 7 : ((i % 2 == 0) ? 9 : 20 + i));
      rob_valid = '1;
      step_to_sample();
      younger = '0;
      for (int i = `NUM_RT_UOP - 1; i >= 0; i--) begin
        exp_strobe[i] = (pass == 0) ? base_of(rob_data[i]) & ~younger : base_of(rob_data[i]);
        younger = younger | base_of(rob_data[i]);
      end
      if (pass == 1)
        exp_strobe[0] = exp_strobe[0] & ~base_of(rob_data[2]);  // only entry 2 overlaps
      compare_vrf_lanes();
    end
  endtask

  task automatic group_break();
    rvv_retire_pkg::rt2xrf_t exp;
    step_to_drive();
    for (int i = 0; i < `NUM_RT_UOP; i++)
      rob_data[i] = make_entry((i == 1) ? rvv_retire_pkg::DST_XRF : rvv_retire_pkg::DST_VRF, 12);
    rob_valid = '1;
    xrf_ready = '1;
    step_to_sample();
    for (int i = 0; i < `NUM_RT_UOP; i++)
      exp_strobe[i] = base_of(rob_data[i]);  // group of one, nothing pruned
    exp = {rob_data[1].w_index, rob_data[1].w_data[`XLEN-1:0]};
    check_valid("rt2vrf_write_valid", 4'b1101, vrf_valid);
    check_valid("rt2xrf_write_valid", 4'b0010, xrf_valid);
    check_xrf("rt2xrf_write_data[1]", exp, xrf_data[1]);
    compare_vrf_lanes();
  endtask

  task automatic xrf_backpressure();
    rvv_retire_pkg::lane_valid_t exp_ready;
    repeat (4) begin
      step_to_drive();
      for (int i = 0; i < `NUM_RT_UOP; i++)
        rob_data[i] = make_entry((i % 2 == 0) ? rvv_retire_pkg::DST_XRF
                                              : rvv_retire_pkg::DST_VRF, i);
      rob_valid = '1;
      xrf_ready = `NUM_RT_UOP'($urandom);
      step_to_sample();
      for (int i = 0; i < `NUM_RT_UOP; i++)
        exp_ready[i] = (i % 2 == 0) ? xrf_ready[i] : 1'b1;
      check_valid("rob2rt_write_ready", exp_ready, rob_ready);
      check_valid("rt2vrf_write_valid", 4'b1010, vrf_valid);
    end
  endtask

  task automatic trap_cutoff();
    step_to_drive();
    for (int i = 0; i < `NUM_RT_UOP; i++)
      rob_data[i] = make_entry(rvv_retire_pkg::DST_VRF, i + 4);
    rob_data[1].trap_flag = 1'b1;
    rob_valid = '1;
    step_to_sample();
    check_valid("rt2vrf_write_valid", 4'b0011, vrf_valid);
    check_bit("rt2vcsr_write_valid", 1'b1, vcsr_valid);
    check_vcsr("rt2vcsr_write_data", rob_data[1].vector_csr, vcsr_data);
    step_to_drive();
    rob_data[1].trap_flag = 1'b0;
    step_to_sample();
    check_valid("rt2vrf_write_valid", '1, vrf_valid);
    check_bit("rt2vcsr_write_valid", 1'b0, vcsr_valid);
    check_vcsr("rt2vcsr_write_data", '0, vcsr_data);
  endtask

  task automatic vxsat_merge();
    step_to_drive();
    for (int i = 0; i < `NUM_RT_UOP; i++)
      rob_data[i] = make_entry(rvv_retire_pkg::DST_VRF, i + 16);
    rob_data[3].vxsat     = 1'b1;
    rob_data[0].trap_flag = 1'b1;  // cuts entry 3
    step_to_sample();
    check_bit("rt2vsat_write_valid", 1'b0, vsat_valid);
    check_bit("rt2vsat_write_data", 1'b1, vsat_data[0]);
    step_to_drive();
    rob_data[0].trap_flag = 1'b0;
    step_to_sample();
    check_bit("rt2vsat_write_valid", 1'b1, vsat_valid);
    check_bit("rt2vsat_write_data", 1'b1, vsat_data[0]);
  endtask

  //////////////////////////////
  // run
  //////////////////////////////

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
  end

  initial begin
    void'($urandom(84));
    rob_valid = '0;
    rob_data  = '0;
    xrf_ready = '0;
    wait_reset_release();
    distinct_vrf_writes();
    waw_pruning();
    group_break();
    xrf_backpressure();
    trap_cutoff();
    vxsat_merge();
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: src/rvv_retire.sv
//////////////////////////////
// retire stage top level
// ctrl, strobe and csr instances,
// VRF/XRF write data packing
//////////////////////////////

`timescale 1ns/1ps

`include "rvv_retire_consts.svh"

module rvv_retire (
  // ROB side
  input  rvv_retire_pkg::lane_valid_t                rob2rt_write_valid,
  input  rvv_retire_pkg::rob2rt_t [`NUM_RT_UOP-1:0]  rob2rt_write_data,
  output rvv_retire_pkg::lane_valid_t                rob2rt_write_ready,
  // XRF write
  output rvv_retire_pkg::lane_valid_t                rt2xrf_write_valid,
  output rvv_retire_pkg::rt2xrf_t [`NUM_RT_UOP-1:0]  rt2xrf_write_data,
  input  rvv_retire_pkg::lane_valid_t                rt2xrf_write_ready,
  // VRF write, no ready
  output rvv_retire_pkg::lane_valid_t                rt2vrf_write_valid,
  output rvv_retire_pkg::rt2vrf_t [`NUM_RT_UOP-1:0]  rt2vrf_write_data,
  // CSR updates
  output logic                                       rt2vcsr_write_valid,
  output rvv_retire_pkg::vcsr_t                      rt2vcsr_write_data,
  output logic                                       rt2vsat_write_valid,
  output logic [`VCSR_VXSAT_WIDTH-1:0]               rt2vsat_write_data
);

  rvv_retire_pkg::group_e             group;
  rvv_retire_pkg::lane_valid_t        lane_keep;   // trap-cut valids
  logic [`NUM_RT_UOP-1:0][`VLENB-1:0] strobe;

  //////////////////////////////
  // submodules
  //////////////////////////////

  rvv_retire_ctrl i_ctrl (
    .rob_valid (rob2rt_write_valid),
    .rob_data  (rob2rt_write_data),
    .xrf_ready (rt2xrf_write_ready),
    .group     (group),
    .lane_keep (lane_keep),
    .vrf_valid (rt2vrf_write_valid),
    .xrf_valid (rt2xrf_write_valid),
    .rob_ready (rob2rt_write_ready)
  );

  rvv_retire_strobe i_strobe (
    .rob_data (rob2rt_write_data),
    .group    (group),
    .strobe   (strobe)
  );

  rvv_retire_csr i_csr (
    .rob_data   (rob2rt_write_data),
    .lane_keep  (lane_keep),
    .vcsr_valid (rt2vcsr_write_valid),
    .vcsr_data  (rt2vcsr_write_data),
    .vsat_valid (rt2vsat_write_valid),
    .vsat_data  (rt2vsat_write_data)
  );

  //////////////////////////////
  // write data packing
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      rt2vrf_write_data[i].rt_index  = rob2rt_write_data[i].w_index;
      rt2vrf_write_data[i].rt_data   = rob2rt_write_data[i].w_data;
      rt2vrf_write_data[i].rt_strobe = strobe[i];  // after WAW pruning

      rt2xrf_write_data[i].rt_index  = rob2rt_write_data[i].w_index;
      rt2xrf_write_data[i].rt_data   = rob2rt_write_data[i].w_data[`XLEN-1:0];  // low word
    end
  end

endmodule

// File: src/rvv_retire_csr.sv
//////////////////////////////
// retire CSR updates
// vcsr restore on trap, vxsat merge
//////////////////////////////

`timescale 1ns/1ps

`include "rvv_retire_consts.svh"

module rvv_retire_csr (
  input  rvv_retire_pkg::rob2rt_t [`NUM_RT_UOP-1:0]  rob_data,
  input  rvv_retire_pkg::lane_valid_t                lane_keep,
  output logic                                       vcsr_valid,
  output rvv_retire_pkg::vcsr_t                      vcsr_data,
  output logic                                       vsat_valid,
  output logic [`VCSR_VXSAT_WIDTH-1:0]               vsat_data
);

  // walk newest to oldest so the oldest trap wins
  always_comb begin
    vcsr_valid = 1'b0;
    vcsr_data  = '0;
    for (int i = `NUM_RT_UOP - 1; i >= 0; i--) begin
      if (rob_data[i].w_valid && rob_data[i].trap_flag) begin
        vcsr_valid = 1'b1;
        vcsr_data  = rob_data[i].vector_csr;
      end
    end
  end

  always_comb begin
    vsat_valid = 1'b0;
    vsat_data  = '0;
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      vsat_valid = vsat_valid | (lane_keep[i] & (|rob_data[i].vxsat));  // kept lanes only
      vsat_data  = vsat_data | rob_data[i].vxsat;  // all entries
    end
  end

endmodule

// File: src/rvv_retire_strobe.sv
//////////////////////////////
// VRF byte strobes
// byte-enable decode, tail/mask policy
// override, WAW pruning in the group
//////////////////////////////

`timescale 1ns/1ps

`include "rvv_retire_consts.svh"

module rvv_retire_strobe (
  input  rvv_retire_pkg::rob2rt_t [`NUM_RT_UOP-1:0]  rob_data,
  input  rvv_retire_pkg::group_e                     group,
  output logic [`NUM_RT_UOP-1:0][`VLENB-1:0]         strobe
);

  logic [`NUM_RT_UOP-1:0][`VLENB-1:0] base_strobe;  // before WAW pruning
  logic [`NUM_RT_UOP-1:0]             full_write;

  //////////////////////////////
  // base strobe
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      full_write[i] = rob_data[i].ignore_vta | rob_data[i].ignore_vma;
    end
  end

  always_comb begin
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      for (int b = 0; b < `VLENB; b++) begin
        base_strobe[i][b] = (rob_data[i].vd_type[b] == `VD_BYTE_ACTIVE);
      end
      // policy ignored, write the whole register
      if (full_write[i]) begin
        base_strobe[i] = '1;
      end
    end
  end

  //////////////////////////////
  // WAW pruning
  //////////////////////////////

  // a younger write to the same register inside the group
  // owns every byte it enables, the older entry loses them
  always_comb begin
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      strobe[i] = base_strobe[i];
      for (int j = i + 1; j < `NUM_RT_UOP; j++) begin
        if ((j <= int'(group)) &&
            (rob_data[j].w_index == rob_data[i].w_index)) begin
          strobe[i] = strobe[i] & ~base_strobe[j];
        end
      end
    end
  end

endmodule

// File: src/rvv_retire_ctrl.sv
//////////////////////////////
// retire control
// destination grouping, trap cut-off,
// VRF/XRF valid split, ROB ready
//////////////////////////////

`timescale 1ns/1ps

`include "rvv_retire_consts.svh"

module rvv_retire_ctrl (
  input  rvv_retire_pkg::lane_valid_t                  rob_valid,
  input  rvv_retire_pkg::rob2rt_t [`NUM_RT_UOP-1:0]    rob_data,
  input  rvv_retire_pkg::lane_valid_t                  xrf_ready,
  output rvv_retire_pkg::group_e                       group,
  output rvv_retire_pkg::lane_valid_t                  lane_keep,
  output rvv_retire_pkg::lane_valid_t                  vrf_valid,
  output rvv_retire_pkg::lane_valid_t                  xrf_valid,
  output rvv_retire_pkg::lane_valid_t                  rob_ready
);

  rvv_retire_pkg::lane_valid_t dst_eq;     // entry matches the one before it
  logic                        grp_run;
  logic [1:0]                  grp_depth;
  logic                        trap_seen;

  //////////////////////////////
  // grouping
  //////////////////////////////

  always_comb begin
    dst_eq[0] = 1'b1;  // entry 0 always opens the group
    for (int i = 1; i < `NUM_RT_UOP; i++) begin
      dst_eq[i] = ({rob_valid[i], rob_data[i].w_type} ==
                   {rob_valid[i-1], rob_data[i-1].w_type});
    end
  end

  // length of the unbroken run from entry 0
  always_comb begin
    grp_run   = 1'b1;
    grp_depth = 2'd0;
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      grp_run = grp_run & dst_eq[i];
      if (grp_run) begin
        grp_depth = 2'(i);
      end
    end
  end

  assign group = rvv_retire_pkg::group_e'(grp_depth);

  //////////////////////////////
  // trap cut-off and valids
  //////////////////////////////

  always_comb begin
    trap_seen = 1'b0;
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      lane_keep[i] = rob_data[i].w_valid & ~trap_seen;  // drop anything younger than a trap
      trap_seen    = trap_seen | rob_data[i].trap_flag;
    end
  end

  always_comb begin
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      vrf_valid[i] = lane_keep[i] & (rob_data[i].w_type == rvv_retire_pkg::DST_VRF);
      xrf_valid[i] = lane_keep[i] & (rob_data[i].w_type == rvv_retire_pkg::DST_XRF);
      // only XRF writes see back-pressure
      rob_ready[i] = xrf_valid[i] ? xrf_ready[i] : 1'b1;
    end
  end

endmodule

// File: src/rvv_retire_pkg.sv
//////////////////////////////
// retire stage types
// destination and group enums,
// ROB entry, VRF/XRF write and vcsr structs
//////////////////////////////

`include "rvv_retire_consts.svh"

package rvv_retire_pkg;

  // write destination of a micro-op
  typedef enum logic {
    DST_VRF = 1'b0,
    DST_XRF = 1'b1
  } w_type_e;

  // run of entries from entry 0 with the same destination kind
  typedef enum logic [1:0] {
    GRP_NONE = 2'd0,  // entry 0 alone
    GRP_01   = 2'd1,
    GRP_012  = 2'd2,
    GRP_0123 = 2'd3
  } group_e;

  typedef logic [`NUM_RT_UOP-1:0] lane_valid_t;

  // vector configuration state, restored on trap
  typedef struct packed {
    logic [15:0] vstart;
    logic [15:0] vl;
    logic [2:0]  vlmul;
    logic [2:0]  vsew;
    logic        vta;
    logic        vma;
    logic [1:0]  vxrm;
  } vcsr_t;

  // one retiring micro-op from the ROB
  typedef struct packed {
    logic                               w_valid;
    w_type_e                            w_type;
    logic [`REGFILE_INDEX_WIDTH-1:0]    w_index;
    logic [`VLEN-1:0]                   w_data;
    logic [`VLENB-1:0][1:0]             vd_type;     // per-byte type code
    logic                               ignore_vta;
    logic                               ignore_vma;
    logic                               trap_flag;
    vcsr_t                              vector_csr;
    logic [`VCSR_VXSAT_WIDTH-1:0]       vxsat;
  } rob2rt_t;

  // VRF write port
  typedef struct packed {
    logic [`REGFILE_INDEX_WIDTH-1:0] rt_index;
    logic [`VLEN-1:0]                rt_data;
    logic [`VLENB-1:0]               rt_strobe;
  } rt2vrf_t;

  // XRF write port
  typedef struct packed {
    logic [`REGFILE_INDEX_WIDTH-1:0] rt_index;
    logic [`XLEN-1:0]                rt_data;
  } rt2xrf_t;

endpackage

// File: src/rvv_retire_consts.svh
//////////////////////////////
// retire stage constants
// lane count, vector and scalar widths,
// register index width, byte type code
//////////////////////////////

`ifndef RVV_RETIRE_CONSTS_SVH
`define RVV_RETIRE_CONSTS_SVH

// retire lanes, entry 0 is the oldest
`define NUM_RT_UOP 4

`define VLEN  128         // vector register width
`define VLENB (`VLEN/8)   // bytes per vector register
`define XLEN  32          // scalar register width

`define REGFILE_INDEX_WIDTH 5

// vd_type code of a byte that is written
`define VD_BYTE_ACTIVE 2'b11

`define VCSR_VXSAT_WIDTH 1

`endif
